// File: testbench/mont_stimulus.dat
// columns: a b m expected, 128-bit hex, expected = a*b*2^-128 mod m
// a line of zeros ends the list
0 0123456789ABCDEFFEDCBA9876543210 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0
1 0123456789ABCDEFFEDCBA9876543210 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0123456789ABCDEFFEDCBA9876543210
10 0123456789ABCDEFFEDCBA9876543210 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 123456789ABCDEFFEDCBA98765432100
10000000000000000 0123456789ABCDEFFEDCBA9876543210 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FEDCBA98765432100123456789ABCDEF
80000000000000000000000000000000 3 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 80000000000000000000000000000001
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE 00000000FFFFFFFF1234567800000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFF00000000EDCBA987FFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 1
3 55555555555555555555555555555555 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0
2 2 3 1
1 2 3 2
3 5 7 2
10000000000000000 5 10000000000000001 FFFFFFFFFFFFFFFC
C8 64 FF 6E
10000 10000 100000001 100000000
10 10 11 1
0 0 0 0

// File: all.f
hdl/mont_sel_pkg.sv
hdl/mont_fsm_pkg.sv
hdl/mont_digit_decode.sv
hdl/mont_execute.sv
hdl/mont_result.sv
hdl/mont_control.sv
hdl/mont_mul_top.sv
testbench/tb_mont_mul.sv

// File: run_sim.sh
#!/bin/sh
# build and run the Montgomery multiplier testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mont_mul -f all.f -o sim_tb_mont_mul
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_mont_mul)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: testbench/tb_mont_mul.sv
`timescale 1ns/1ps

module tb_mont_mul;

    localparam int WIDTH        = 128;
    localparam int ITER_COUNT   = WIDTH / 2;
    // one prep edge, one edge per digit, one reduce edge
    localparam int LATENCY      = ITER_COUNT + 2;
    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 4;
    localparam int SLACK_CYCLES = 64;
    localparam int MAX_VECTORS  = 32;
    localparam int SEED         = 54;
    localparam string STIM_FILE = "testbench/mont_stimulus.dat";

    logic             clk;
    logic             resetn;
    logic             in_valid;
    logic             in_ready;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] m;
    logic [WIDTH-1:0] result;
    logic             out_valid;
    logic             out_ready;

    // four words per vector: a, b, m, expected
    logic [WIDTH-1:0] stim_mem [0:4*MAX_VECTORS-1];
    int               num_vectors;

    mont_mul_top #(
        .OPERAND_WIDTH (WIDTH)
    ) mont_mul_top_inst (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .m         (m),
        .result    (result),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_result(
        input logic [WIDTH-1:0] got,
        input logic [WIDTH-1:0] exp_value,
        input string            what
    );
        if (got !== exp_value) begin
            $display("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp_value);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(
        input int    got,
        input int    exp_cycles,
        input string what
    );
        if (got != exp_cycles) begin
            $display("ERR @%0t ns: %s is %0d cycles, expected %0d", $time, what, got,
                     exp_cycles);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(
        input logic  got,
        input logic  exp_value,
        input string what
    );
        if (got !== exp_value) begin
            $display("ERR @%0t ns: %s is %b, expected %b", $time, what, got, exp_value);
            stop_with_failure();
        end
    endtask

    // inputs change a little after the edge, outputs are settled by then
    task automatic tick();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic drive_vector(input int idx);
        a        = stim_mem[4*idx];
        b        = stim_mem[4*idx+1];
        m        = stim_mem[4*idx+2];
        in_valid = 1'b1;
    endtask

    // watchdog, scaled by the number of vectors in the file
    initial begin
        longint limit_ns;
        @(posedge resetn);
        limit_ns = longint'(num_vectors) * (LATENCY + SLACK_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns after reset", limit_ns);
        stop_with_failure();
    end

    initial begin
        int               lat;
        logic             taken;
        logic [WIDTH-1:0] held;
        logic [WIDTH-1:0] expected;

        resetn      = 1'b0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        a           = '0;
        b           = '0;
        m           = '0;
        num_vectors = 0;
        void'($urandom(SEED));

        $readmemh(STIM_FILE, stim_mem);
        // a zero modulus ends the list
        while (num_vectors < MAX_VECTORS && stim_mem[4*num_vectors+2] != '0) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("the stimulus file %s holds no vectors", STIM_FILE);
            stop_with_failure();
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        resetn = 1'b1;
        check_flag(in_ready, 1'b1, "in_ready after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");

        drive_vector(0);
        for (int v = 0; v < num_vectors; v++) begin
            expected = stim_mem[4*v+3];
            while (!in_ready) begin
                tick();
            end
            // the accepting edge
            tick();
            if (v + 1 < num_vectors) begin
                // next operands wait at the input while this one runs
                drive_vector(v + 1);
            end else begin
                in_valid = 1'b0;
            end

            lat = 0;
            while (!out_valid) begin
                check_flag(in_ready, 1'b0, "in_ready while busy");
                out_ready = ($urandom() % 2) == 1;
                tick();
                lat++;
            end
            check_latency(lat, LATENCY, $sformatf("latency of vector %0d", v));
            check_result(result, expected, $sformatf("result of vector %0d", v));

            // random stalls, output must hold until taken
            held  = result;
            taken = 1'b0;
            while (!taken) begin
                check_flag(out_valid, 1'b1, "out_valid before transfer");
                check_result(result, held, "result under stall");
                check_flag(in_ready, 1'b0, "in_ready with unread result");
                out_ready = ($urandom() % 2) == 1;
                taken     = out_ready;
                tick();
            end
            out_ready = 1'b0;
            check_flag(out_valid, 1'b0, "out_valid after transfer");
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/mont_mul_top.sv
`timescale 1ns/1ps

module mont_mul_top #(
    parameter int OPERAND_WIDTH = 1024
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [OPERAND_WIDTH-1:0] a,
    input  logic [OPERAND_WIDTH-1:0] b,
    input  logic [OPERAND_WIDTH-1:0] m,
    output logic [OPERAND_WIDTH-1:0] result,
    output logic                     out_valid,
    input  logic                     out_ready
);

    logic                     load;
    logic                     prep;
    logic                     step;
    logic                     reduce;
    logic [OPERAND_WIDTH+1:0] acc;
    logic [OPERAND_WIDTH-1:0] m_held;

    mont_control #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) control_inst (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .m_odd     (m[0]),
        .in_ready  (in_ready),
        .load      (load),
        .prep      (prep),
        .step      (step),
        .reduce    (reduce)
    );

    mont_execute #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) execute_inst (
        .clk    (clk),
        .resetn (resetn),
        .load   (load),
        .prep   (prep),
        .step   (step),
        .a      (a),
        .b      (b),
        .m      (m),
        .acc    (acc),
        .m_held (m_held)
    );

    // m comes from execute's copy, the input may already hold the next vector
    mont_result #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) result_inst (
        .clk       (clk),
        .resetn    (resetn),
        .reduce    (reduce),
        .acc       (acc),
        .m         (m_held),
        .out_ready (out_ready),
        .result    (result),
        .out_valid (out_valid)
    );

endmodule

// File: hdl/mont_control.sv
`timescale 1ns/1ps

module mont_control
    import mont_fsm_pkg::*;
#(
    parameter int OPERAND_WIDTH = 1024
) (
    input  logic clk,
    input  logic resetn,
    input  logic in_valid,
    input  logic out_valid,
    input  logic m_odd,
    output logic in_ready,
    output logic load,
    output logic prep,
    output logic step,
    output logic reduce
);

    localparam int ITER_COUNT = OPERAND_WIDTH / 2;
    localparam int CNT_WIDTH  = $clog2(ITER_COUNT + 1);
    localparam logic [CNT_WIDTH-1:0] LAST_ITER = CNT_WIDTH'(ITER_COUNT - 1);

    mont_phase_t          phase;
    logic [CNT_WIDTH-1:0] iter_cnt;

    // only accept once the previous result has been taken
    assign in_ready = (phase == PH_IDLE) && !out_valid;
    assign load     = in_valid && in_ready;
    assign prep     = (phase == PH_PREP);
    assign step     = (phase == PH_LOOP);
    assign reduce   = (phase == PH_REDUCE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase    <= PH_IDLE;
            iter_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    iter_cnt <= '0;
                    if (load) begin
                        phase <= PH_PREP;
                    end
                end
                PH_PREP: begin
                    phase <= PH_LOOP;
                end
                PH_LOOP: begin
                    if (iter_cnt == LAST_ITER) begin
                        iter_cnt <= '0;
                        phase    <= PH_REDUCE;
                    end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                default: begin
                    // reduce lasts a single cycle
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // montgomery reduction needs an odd modulus
    a_modulus_odd: assert property (
        @(posedge clk) disable iff (!resetn)
        load |-> m_odd
    ) else $error("accepted an even modulus");

endmodule

// File: hdl/mont_result.sv
`timescale 1ns/1ps

module mont_result #(
    parameter int OPERAND_WIDTH = 1024
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     reduce,
    input  logic [OPERAND_WIDTH+1:0] acc,
    input  logic [OPERAND_WIDTH-1:0] m,
    input  logic                     out_ready,
    output logic [OPERAND_WIDTH-1:0] result,
    output logic                     out_valid
);

    localparam int ACC_WIDTH = OPERAND_WIDTH + 2;

    // acc - m with a borrow bit on top
    logic [ACC_WIDTH:0]       diff;
    logic                     acc_below_m;
    logic [OPERAND_WIDTH-1:0] reduced;

    assign diff        = {1'b0, acc} - {3'b000, m};
    assign acc_below_m = diff[ACC_WIDTH];

    // acc < 2m, so one subtraction is enough
    assign reduced = acc_below_m ? acc[OPERAND_WIDTH-1:0] : diff[OPERAND_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reduce) begin
            result <= reduced;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (reduce) begin
            out_valid <= 1'b1;
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held output must not move while the consumer stalls
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(result))
    ) else $error("result changed while stalled");

    // m here is the copy held in execute, fixed until the next load
    a_fully_reduced: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid |-> (result < m)
    ) else $error("result not reduced below modulus");

endmodule

// File: hdl/mont_execute.sv
`timescale 1ns/1ps

module mont_execute
    import mont_sel_pkg::*;
#(
    parameter int OPERAND_WIDTH = 1024
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load,
    input  logic                     prep,
    input  logic                     step,
    input  logic [OPERAND_WIDTH-1:0] a,
    input  logic [OPERAND_WIDTH-1:0] b,
    input  logic [OPERAND_WIDTH-1:0] m,
    output logic [OPERAND_WIDTH+1:0] acc,
    output logic [OPERAND_WIDTH-1:0] m_held
);

    localparam int ACC_WIDTH = OPERAND_WIDTH + 2;
    // one extra bit for acc + 3b + 3m before the shift
    localparam int SUM_WIDTH = ACC_WIDTH + 1;

    logic [OPERAND_WIDTH-1:0] b_q;
    logic [OPERAND_WIDTH-1:0] m_q;
    logic [OPERAND_WIDTH+1:0] b3_q;
    logic [OPERAND_WIDTH+1:0] m3_q;
    logic [OPERAND_WIDTH-1:0] a_shift;

    mult_sel_t            sel_b;
    mult_sel_t            sel_m;
    logic [SUM_WIDTH-1:0] add_b;
    logic [SUM_WIDTH-1:0] add_m;
    logic [SUM_WIDTH-1:0] sum;

    // zero, x, 2x or 3x, all widened to the sum width
    function automatic logic [SUM_WIDTH-1:0] pick_multiple(
        input mult_sel_t                sel,
        input logic [OPERAND_WIDTH-1:0] one,
        input logic [OPERAND_WIDTH+1:0] three
    );
        logic [SUM_WIDTH-1:0] value;
        case (sel)
            SEL_ONE:   value = {3'b000, one};
            SEL_TWO:   value = {2'b00, one, 1'b0};
            SEL_THREE: value = {1'b0, three};
            default:   value = '0;
        endcase
        return value;
    endfunction

    mont_digit_decode digit_decode_inst (
        .a_digit (a_shift[1:0]),
        .acc_low (acc[1:0]),
        .b_low   (b_q[1:0]),
        .m_low   (m_q[1:0]),
        .sel_b   (sel_b),
        .sel_m   (sel_m)
    );

    assign add_b = pick_multiple(sel_b, b_q, b3_q);
    assign add_m = pick_multiple(sel_m, m_q, m3_q);
    assign sum   = {1'b0, acc} + add_b + add_m;

    // operand registers
    always_ff @(posedge clk) begin
        if (load) begin
            b_q <= b;
            m_q <= m;
        end
        if (prep) begin
            b3_q <= {2'b00, b_q} + {1'b0, b_q, 1'b0};
            m3_q <= {2'b00, m_q} + {1'b0, m_q, 1'b0};
        end
    end

    // digits of a leave from the bottom, two per step
    always_ff @(posedge clk) begin
        if (load) begin
            a_shift <= a;
        end else if (step) begin
            a_shift <= {2'b00, a_shift[OPERAND_WIDTH-1:2]};
        end
    end

    // accumulator stays below 2m after every step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else if (load) begin
            acc <= '0;
        end else if (step) begin
            acc <= {1'b0, sum[SUM_WIDTH-1:2]};
        end
    end

    assign m_held = m_q;

    // the quotient digit from decode must clear the low two bits
    a_low_bits_clear: assert property (
        @(posedge clk) disable iff (!resetn)
        step |-> (sum[1:0] == 2'b00)
    ) else $error("montgomery step left nonzero low bits");

endmodule

// File: hdl/mont_digit_decode.sv
`timescale 1ns/1ps

module mont_digit_decode
    import mont_sel_pkg::*;
(
    input  logic [1:0] a_digit,
    input  logic [1:0] acc_low,
    input  logic [1:0] b_low,
    input  logic [1:0] m_low,
    output mult_sel_t  sel_b,
    output mult_sel_t  sel_m
);

    // low bits of acc + digit*b, taken mod 4
    logic [1:0] partial_low;
    // negated partial, mod 4
    logic [1:0] partial_neg;
    // quotient digit q = -partial * m^-1 mod 4
    logic [1:0] q_digit;

    assign partial_low = acc_low + a_digit * b_low;
    assign partial_neg = 2'd0 - partial_low;

    // m odd, so m is its own inverse mod 4 (1*1 = 1, 3*3 = 9)
    assign q_digit = partial_neg * m_low;

    always_comb begin
        case (a_digit)
            2'd1:    sel_b = SEL_ONE;
            2'd2:    sel_b = SEL_TWO;
            2'd3:    sel_b = SEL_THREE;
            default: sel_b = SEL_ZERO;
        endcase
    end

    always_comb begin
        case (q_digit)
            2'd1:    sel_m = SEL_ONE;
            2'd2:    sel_m = SEL_TWO;
            2'd3:    sel_m = SEL_THREE;
            default: sel_m = SEL_ZERO;
        endcase
    end

endmodule

// File: hdl/mont_fsm_pkg.sv
package mont_fsm_pkg;

    // controller phases
    // idle:   waiting for an operand set and an empty output
    // prep:   one cycle to register 3b and 3m
    // loop:   one add-and-shift per a digit
    // reduce: final conditional subtraction into the output register
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_PREP   = 2'd1,
        PH_LOOP   = 2'd2,
        PH_REDUCE = 2'd3
    } mont_phase_t;

endpackage

// File: hdl/mont_sel_pkg.sv
package mont_sel_pkg;

    // which multiple of b or m goes into the accumulator
    // the encoding equals the multiplier itself, so a radix-4
    // digit maps straight onto it
    typedef enum logic [1:0] {
        SEL_ZERO  = 2'd0,
        SEL_ONE   = 2'd1,
        SEL_TWO   = 2'd2,
        SEL_THREE = 2'd3
    } mult_sel_t;

endpackage
